// ==== logic/aes_dec_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_dec_ctrl
    import aes_dec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      next,
    input  keylen_e   keylen,
    output round_t    round_no,
    output word_sel_t word_sel,
    output update_e   update,
    output logic      ready
);

    dec_state_e state_reg;
    dec_state_e state_next;
    round_t     round_ctr;
    word_sel_t  word_ctr;
    logic       ready_reg;
    logic       round_set;
    logic       round_dec;
    logic       word_rst;
    logic       word_inc;
    logic       ready_set;
    logic       ready_clr;

    assign round_no = round_ctr;
    assign word_sel = word_ctr;
    assign ready    = ready_reg;

    always_comb
    begin
        state_next = state_reg;
        update     = UPD_NONE;
        round_set  = 1'b0;
        round_dec  = 1'b0;
        word_rst   = 1'b0;
        word_inc   = 1'b0;
        ready_set  = 1'b0;
        ready_clr  = 1'b0;
        case (state_reg)
            DEC_IDLE:
            begin
                if (next)
                begin
                    round_set  = 1'b1;
                    ready_clr  = 1'b1;
                    state_next = DEC_INIT;
                end
            end
            DEC_INIT:
            begin
                update     = UPD_INIT;
                word_rst   = 1'b1;
                state_next = DEC_SBOX;
            end
            DEC_SBOX:
            begin
                update   = UPD_SBOX;
                word_inc = 1'b1;
                // last column done so the key of the next round is due
                if (word_ctr == 2'd3)
                begin
                    round_dec  = 1'b1;
                    state_next = DEC_MAIN;
                end
            end
            DEC_MAIN:
            begin
                word_rst = 1'b1;
                if (round_ctr != '0)
                begin
                    update     = UPD_MAIN;
                    state_next = DEC_SBOX;
                end
                else
                begin
                    update     = UPD_FINAL;
                    ready_set  = 1'b1;
                    state_next = DEC_IDLE;
                end
            end
            default:
            begin
                state_next = DEC_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state_reg <= DEC_IDLE;
            round_ctr <= '0;
            word_ctr  <= '0;
            ready_reg <= 1'b1;
        end
        else
        begin
            state_reg <= state_next;
            if (round_set)
            begin
                round_ctr <= (keylen == KEY_256) ? ROUNDS_256 : ROUNDS_128;
            end
            else if (round_dec)
            begin
                round_ctr <= round_ctr - 4'd1;
            end
            if (word_rst)
            begin
                word_ctr <= '0;
            end
            else if (word_inc)
            begin
                word_ctr <= word_ctr + 2'd1;
            end
            if (ready_clr)
            begin
                ready_reg <= 1'b0;
            end
            else if (ready_set)
            begin
                ready_reg <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/aes_dec_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_dec_datapath
    import aes_dec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  update_e   update,
    input  word_sel_t word_sel,
    input  block_t    block,
    input  block_t    round_key,
    input  word_t     sbox_out,
    output word_t     sbox_in,
    output block_t    state
);

    word_t      w_reg [4];
    block_t     block_new;
    logic [3:0] word_we;

    function automatic word_t inv_mix_word(word_t w);
        byte_t b0;
        byte_t b1;
        byte_t b2;
        byte_t b3;
        byte_t m0;
        byte_t m1;
        byte_t m2;
        byte_t m3;
        b0 = w[31:24];
        b1 = w[23:16];
        b2 = w[15:8];
        b3 = w[7:0];
        m0 = gf_mul(b0, 8'h0e) ^ gf_mul(b1, 8'h0b) ^ gf_mul(b2, 8'h0d) ^ gf_mul(b3, 8'h09);
        m1 = gf_mul(b0, 8'h09) ^ gf_mul(b1, 8'h0e) ^ gf_mul(b2, 8'h0b) ^ gf_mul(b3, 8'h0d);
        m2 = gf_mul(b0, 8'h0d) ^ gf_mul(b1, 8'h09) ^ gf_mul(b2, 8'h0e) ^ gf_mul(b3, 8'h0b);
        m3 = gf_mul(b0, 8'h0b) ^ gf_mul(b1, 8'h0d) ^ gf_mul(b2, 8'h09) ^ gf_mul(b3, 8'h0e);
        return {m0, m1, m2, m3};
    endfunction

    function automatic block_t inv_mixcolumns(block_t d);
        return {inv_mix_word(d[127:96]), inv_mix_word(d[95:64]),
                inv_mix_word(d[63:32]), inv_mix_word(d[31:0])};
    endfunction

    // row r moves r columns to the right
    function automatic block_t inv_shiftrows(block_t d);
        word_t w0;
        word_t w1;
        word_t w2;
        word_t w3;
        w0 = d[127:96];
        w1 = d[95:64];
        w2 = d[63:32];
        w3 = d[31:0];
        return {w0[31:24], w3[23:16], w2[15:8], w1[7:0],
                w1[31:24], w0[23:16], w3[15:8], w2[7:0],
                w2[31:24], w1[23:16], w0[15:8], w3[7:0],
                w3[31:24], w2[23:16], w1[15:8], w0[7:0]};
    endfunction

    assign state   = {w_reg[0], w_reg[1], w_reg[2], w_reg[3]};
    assign sbox_in = w_reg[word_sel];

    always_comb
    begin
        block_new = '0;
        word_we   = 4'b0000;
        case (update)
            UPD_INIT:
            begin
                block_new = inv_shiftrows(block ^ round_key);
                word_we   = 4'b1111;
            end
            UPD_SBOX:
            begin
                // only the selected column is written back
                block_new         = {4{sbox_out}};
                word_we[word_sel] = 1'b1;
            end
            UPD_MAIN:
            begin
                block_new = inv_shiftrows(inv_mixcolumns(state ^ round_key));
                word_we   = 4'b1111;
            end
            UPD_FINAL:
            begin
                block_new = state ^ round_key;
                word_we   = 4'b1111;
            end
            default:
            begin
                word_we = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            for (int i = 0; i < 4; i++)
            begin
                w_reg[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (word_we[i])
                begin
                    w_reg[i] <= block_new[127 - 32*i -: 32];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/aes_dec_pkg.sv ====
`default_nettype none

package aes_dec_pkg;

    typedef logic [7:0]   byte_t;
    typedef logic [31:0]  word_t;
    typedef logic [127:0] block_t;
    typedef logic [3:0]   round_t;
    typedef logic [1:0]   word_sel_t;

    typedef enum logic {KEY_128 = 1'b0, KEY_256 = 1'b1} keylen_e;

    typedef enum logic [1:0] {DEC_IDLE, DEC_INIT, DEC_SBOX, DEC_MAIN} dec_state_e;

    typedef enum logic [2:0] {UPD_NONE, UPD_INIT, UPD_SBOX, UPD_MAIN, UPD_FINAL} update_e;

    localparam round_t ROUNDS_128 = 4'd10;
    localparam round_t ROUNDS_256 = 4'd14;

    // xtime with reduction by the AES polynomial on overflow
    function automatic byte_t gf_mul2(byte_t a);
        return {a[6:0], 1'b0} ^ (8'h1b & {8{a[7]}});
    endfunction

    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t acc;
        byte_t p;
        acc = '0;
        p = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
            begin
                acc = acc ^ p;
            end
            p = gf_mul2(p);
        end
        return acc;
    endfunction

endpackage

`default_nettype wire

// ==== logic/aes_decode_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_decode_block
    import aes_dec_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    next,
    input  keylen_e keylen,
    output round_t  round_no,
    input  block_t  round_key,
    input  block_t  block,
    output block_t  new_block,
    output logic    ready
);

    word_sel_t word_sel;
    update_e   update;
    word_t     sbox_in;
    word_t     sbox_out;

    aes_dec_ctrl i_ctrl (
        .clk      (clk),
        .reset    (reset),
        .next     (next),
        .keylen   (keylen),
        .round_no (round_no),
        .word_sel (word_sel),
        .update   (update),
        .ready    (ready)
    );

    aes_dec_datapath i_datapath (
        .clk       (clk),
        .reset     (reset),
        .update    (update),
        .word_sel  (word_sel),
        .block     (block),
        .round_key (round_key),
        .sbox_out  (sbox_out),
        .sbox_in   (sbox_in),
        .state     (new_block)
    );

    // single shared S-box handles one column per cycle
    aes_inv_sbox i_sbox (
        .sbox_in  (sbox_in),
        .sbox_out (sbox_out)
    );

endmodule

`default_nettype wire

// ==== logic/aes_inv_sbox.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_inv_sbox
    import aes_dec_pkg::*;
(
    input  word_t sbox_in,
    output word_t sbox_out
);

    // inverse of the forward affine step
    function automatic byte_t inv_affine(byte_t b);
        byte_t r1;
        byte_t r3;
        byte_t r6;
        r1 = {b[6:0], b[7]};
        r3 = {b[4:0], b[7:5]};
        r6 = {b[1:0], b[7:2]};
        return r1 ^ r3 ^ r6 ^ 8'h05;
    endfunction

    // a^254 is the inverse for nonzero a and gives 0 for 0
    function automatic byte_t gf_inv(byte_t a);
        byte_t y;
        y = a;
        for (int i = 0; i < 6; i++)
        begin
            y = gf_mul(gf_mul(y, y), a);
        end
        return gf_mul(y, y);
    endfunction

    function automatic byte_t inv_sub_byte(byte_t a);
        return gf_inv(inv_affine(a));
    endfunction

    // one copy per byte of the column
    for (genvar i = 0; i < 4; i++)
    begin : g_byte
        assign sbox_out[8*i +: 8] = inv_sub_byte(sbox_in[8*i +: 8]);
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the AES decryption testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
    -f verilog.f --top-module tb_aes_decode -o tb_aes_decode \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_aes_decode +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -qx "TEST PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== sim/aes_decode_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_decode_props
    import aes_dec_pkg::*;
(
    input logic   clk,
    input logic   reset,
    input logic   next,
    input logic   ready,
    input round_t round_no
);

    int ready_fails = 0;
    int range_fails = 0;
    int round_fails = 0;

    // a start is only taken while idle
    property p_ready_falls;
        @(posedge clk) disable iff (!reset)
        (next && ready) |=> !ready;
    endproperty

    property p_round_range;
        @(posedge clk) disable iff (!reset)
        round_no <= ROUNDS_256;
    endproperty

    // the load itself may happen while ready is still high
    property p_round_busy_only;
        @(posedge clk) disable iff (!reset)
        (round_no != $past(round_no)) |-> (!ready || $past(next && ready));
    endproperty

    a_ready_falls: assert property (p_ready_falls)
    else
    begin
        $error("ready still high one cycle after an accepted start");
        ready_fails++;
    end

    a_round_range: assert property (p_round_range)
    else
    begin
        $error("round number above 14");
        range_fails++;
    end

    a_round_busy_only: assert property (p_round_busy_only)
    else
    begin
        $error("round number changed while the core was idle");
        round_fails++;
    end

endmodule

bind aes_decode_block aes_decode_props i_props (
    .clk      (clk),
    .reset    (reset),
    .next     (next),
    .ready    (ready),
    .round_no (round_no)
);

`default_nettype wire

// ==== include/aes_ref_model.svh ====
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

function automatic logic [7:0] ref_gmul(logic [7:0] a, logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] p;
    acc = 8'h00;
    p = a;
    for (int i = 0; i < 8; i++)
    begin
        if (b[i])
        begin
            acc = acc ^ p;
        end
        p = {p[6:0], 1'b0} ^ (p[7] ? 8'h1b : 8'h00);
    end
    return acc;
endfunction

// multiplicative inverse found by search
function automatic logic [7:0] ref_inv_sbox(logic [7:0] a);
    logic [7:0] s;
    logic [7:0] inv;
    s = {a[6:0], a[7]} ^ {a[4:0], a[7:5]} ^ {a[1:0], a[7:2]} ^ 8'h05;
    inv = 8'h00;
    for (int x = 1; x < 256; x++)
    begin
        if (ref_gmul(s, 8'(x)) == 8'h01)
        begin
            inv = 8'(x);
        end
    end
    return inv;
endfunction

// byte (row r, column c) sits at bit 127 - 8*(4c + r)
function automatic logic [127:0] ref_inv_shift_rows(logic [127:0] d);
    logic [127:0] o;
    for (int c = 0; c < 4; c++)
    begin
        for (int r = 0; r < 4; r++)
        begin
            o[127 - 8*(4*c + r) -: 8] = d[127 - 8*(4*((c - r + 4) % 4) + r) -: 8];
        end
    end
    return o;
endfunction

function automatic logic [127:0] ref_inv_sub_bytes(logic [127:0] d);
    logic [127:0] o;
    for (int i = 0; i < 16; i++)
    begin
        o[8*i +: 8] = ref_inv_sbox(d[8*i +: 8]);
    end
    return o;
endfunction

function automatic logic [127:0] ref_inv_mix_columns(logic [127:0] d);
    logic [127:0] o;
    logic [7:0]   coef [4];
    logic [7:0]   acc;
    coef = '{8'h0e, 8'h0b, 8'h0d, 8'h09};
    for (int c = 0; c < 4; c++)
    begin
        for (int r = 0; r < 4; r++)
        begin
            acc = 8'h00;
            for (int k = 0; k < 4; k++)
            begin
                acc = acc ^ ref_gmul(coef[(k - r + 4) % 4], d[127 - 8*(4*c + k) -: 8]);
            end
            o[127 - 8*(4*c + r) -: 8] = acc;
        end
    end
    return o;
endfunction

function automatic logic [127:0] ref_decrypt(logic [127:0] ct, logic [127:0] keys [15],
                                             int nr);
    logic [127:0] s;
    s = ref_inv_sub_bytes(ref_inv_shift_rows(ct ^ keys[nr]));
    for (int r = nr - 1; r >= 1; r--)
    begin
        s = ref_inv_mix_columns(s ^ keys[r]);
        s = ref_inv_sub_bytes(ref_inv_shift_rows(s));
    end
    return s ^ keys[0];
endfunction

`endif

// ==== sim/tb_aes_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_aes_decode
    import aes_dec_pkg::*;
();

    `include "aes_ref_model.svh"

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_BLOCKS   = 24;
    localparam int BLOCK_CYCLES = 72;
    localparam int DONE_LIMIT   = 100;
    localparam int WATCHDOG_NS  = (NUM_BLOCKS * BLOCK_CYCLES + RESET_CYCLES + 20) * CLK_PERIOD;

    logic    clk = 1'b0;
    logic    reset;
    logic    next;
    keylen_e keylen;
    round_t  round_no;
    block_t  round_key = '0;
    block_t  block;
    block_t  new_block;
    logic    ready;

    logic [127:0] keys [15];
    integer       seed;
    int           error_count;
    int           blocks_checked;

    aes_decode_block i_dut (
        .clk       (clk),
        .reset     (reset),
        .next      (next),
        .keylen    (keylen),
        .round_no  (round_no),
        .round_key (round_key),
        .block     (block),
        .new_block (new_block),
        .ready     (ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // key for the round the core asks for
    always @(posedge clk)
    begin
        #(DRIVE_DELAY);
        round_key = keys[round_no];
    end

    task automatic report_error(input string msg);
        error_count++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("%s", msg);
    endtask

    function automatic logic [127:0] random_block();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic new_keys();
        for (int i = 0; i < 15; i++)
        begin
            keys[i] = random_block();
        end
    endtask

    // returns 2 ns after the edge that takes the strobe
    task automatic start_block(input logic [127:0] ct, input keylen_e kl);
        block  = ct;
        keylen = kl;
        next   = 1'b1;
        @(posedge clk);
        #(DRIVE_DELAY);
        next = 1'b0;
    endtask

    task automatic wait_ready(output int edges);
        edges = 0;
        while (!ready && edges < DONE_LIMIT)
        begin
            @(posedge clk);
            #(DRIVE_DELAY);
            edges++;
        end
        if (!ready)
        begin
            report_failure($sformatf("ready did not come back within %0d cycles", DONE_LIMIT));
        end
    endtask

    task automatic check_reset_values();
        if (ready !== 1'b1)
            report_error($sformatf("ready is %b after reset", ready));
        if (round_no !== 4'd0)
            report_error($sformatf("round_no is %0d after reset", round_no));
        if (new_block !== '0)
            report_error($sformatf("new_block is %h after reset", new_block));
    endtask

    // decrypt one block with fresh keys and check result and latency
    task automatic decrypt_and_check(input keylen_e kl);
        logic [127:0] ct;
        logic [127:0] expected;
        int           nr;
        int           edges;
        nr = (kl == KEY_256) ? 14 : 10;
        new_keys();
        ct = random_block();
        expected = ref_decrypt(ct, keys, nr);
        start_block(ct, kl);
        if (round_no !== round_t'(nr))
            report_error($sformatf("round_no is %0d after start, expected %0d", round_no, nr));
        wait_ready(edges);
        if (edges != 5 * nr + 1)
            report_error($sformatf("latency %0d edges, expected %0d", edges, 5 * nr + 1));
        if (round_no !== 4'd0)
            report_error($sformatf("round_no is %0d at the end", round_no));
        if (new_block !== expected)
            report_error($sformatf("new_block %h, expected %h", new_block, expected));
        blocks_checked++;
    endtask

    // round_no counts down once every five edges
    task automatic trace_rounds(input keylen_e kl);
        logic [127:0] ct;
        logic [127:0] expected;
        int           nr;
        int           k;
        nr = (kl == KEY_256) ? 14 : 10;
        new_keys();
        ct = random_block();
        expected = ref_decrypt(ct, keys, nr);
        start_block(ct, kl);
        k = 0;
        while (k <= 5 * nr)
        begin
            if (ready !== 1'b0)
                report_error($sformatf("ready rose too early, %0d edges after start", k));
            if (round_no !== round_t'(nr - k / 5))
                report_error($sformatf("round_no %0d at edge %0d, expected %0d",
                                       round_no, k, nr - k / 5));
            @(posedge clk);
            #(DRIVE_DELAY);
            k++;
        end
        if (ready !== 1'b1)
            report_error($sformatf("ready still low %0d edges after start", k));
        if (round_no !== 4'd0)
            report_error($sformatf("round_no is %0d at the end", round_no));
        if (new_block !== expected)
            report_error($sformatf("new_block %h, expected %h", new_block, expected));
        blocks_checked++;
    endtask

    task automatic check_busy_inputs();
        logic [127:0] ct;
        logic [127:0] expected;
        logic [127:0] held;
        int           edges;
        new_keys();
        ct = random_block();
        expected = ref_decrypt(ct, keys, 10);
        start_block(ct, KEY_128);
        // block was taken by the INIT edge
        @(posedge clk);
        #(DRIVE_DELAY);
        edges  = 1;
        block  = random_block();
        keylen = KEY_256;
        while (!ready && edges < DONE_LIMIT)
        begin
            next = (edges % 6 == 2) && (edges < 40);
            @(posedge clk);
            #(DRIVE_DELAY);
            edges++;
        end
        next = 1'b0;
        if (edges != 51)
            report_error($sformatf("latency %0d edges with busy inputs, expected 51", edges));
        if (new_block !== expected)
            report_error($sformatf("new_block %h, expected %h", new_block, expected));
        held = new_block;
        repeat (10)
        begin
            @(posedge clk);
            #(DRIVE_DELAY);
            if (new_block !== held || ready !== 1'b1)
                report_error($sformatf("idle output changed to %h, ready %b", new_block, ready));
        end
        keylen = KEY_128;
        blocks_checked++;
    endtask

    task automatic run_back_to_back();
        for (int i = 0; i < 4; i++)
        begin
            decrypt_and_check((i % 2 == 1) ? KEY_256 : KEY_128);
        end
    endtask

    initial
    begin
        seed           = 32'hf980;
        error_count    = 0;
        blocks_checked = 0;
        reset          = 1'b0;
        next           = 1'b0;
        keylen         = KEY_128;
        block          = '0;
        for (int i = 0; i < 15; i++)
        begin
            keys[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b1;
        check_reset_values();
        repeat (8) decrypt_and_check(KEY_128);
        repeat (8) decrypt_and_check(KEY_256);
        trace_rounds(KEY_128);
        trace_rounds(KEY_256);
        check_busy_inputs();
        run_back_to_back();
        error_count += i_dut.i_props.ready_fails + i_dut.i_props.range_fails
                       + i_dut.i_props.round_fails;
        $display("blocks checked: %0d, errors: %0d", blocks_checked, error_count);
        if (error_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("simulation ran past its time limit, the core seems stuck");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
logic/aes_dec_pkg.sv
logic/aes_inv_sbox.sv
logic/aes_dec_datapath.sv
logic/aes_dec_ctrl.sv
logic/aes_decode_block.sv
sim/aes_decode_props.sv
sim/tb_aes_decode.sv
